//--- Bender.yml
package:
  name: cart_loader

sources:
  - src/cart_pkg.sv
  - src/cart_stream_if.sv
  - src/load_stream_decode.sv
  - src/header_parser.sv
  - src/cheat_assembler.sv
  - src/ram_clear.sv
  - src/backup_sequencer.sv
  - src/cart_loader_top.sv
  - target: test
    files:
      - tb/tb_cart_loader.sv

//--- files.f
src/cart_pkg.sv
src/cart_stream_if.sv
src/load_stream_decode.sv
src/header_parser.sv
src/cheat_assembler.sv
src/ram_clear.sv
src/backup_sequencer.sv
src/cart_loader_top.sv
tb/tb_cart_loader.sv

//--- src/backup_sequencer.sv
// Host must hold sd_ack for a whole 512-byte block; save RAM is assumed to start at block 0
`timescale 1ns/10ps

module backup_sequencer (
	input  logic            clk_sys,
	input  logic            RESET,
	cart_stream_if.sink     stream,
	input  cart_pkg::mask_t ram_mask,
	input  logic            img_mounted,
	input  logic            img_readonly,
	input  logic [63:0]     img_size,
	input  logic            bk_load,
	input  logic            bk_save,
	input  logic            autosave,
	input  logic            osd_open,
	input  logic            bsram_write,
	output cart_pkg::lba_t  sd_lba,
	output logic            sd_rd,
	output logic            sd_wr,
	input  logic            sd_ack,
	output logic            bk_busy,
	output logic            bk_loading,
	output logic            bk_pending
);
	import cart_pkg::*;

	bk_state_e state;
	logic      bk_ena;
	logic      load_q;
	logic      save_q;
	logic      ack_q;
	logic      load_req;
	logic      save_req;
	logic      begin_load;
	logic      begin_save;
	logic      xfer_start;
	logic      block_done;
	logic      last_block;

	// ====================
	// Request edges
	// ====================
	assign load_req = bk_load & bk_ena;
	assign save_req = (bk_save | (bk_pending & osd_open & autosave)) & bk_ena;

	// Image is read back right after the cartridge has loaded
	assign begin_load = (load_req & ~load_q) | (stream.load_end & (|img_size) & bk_ena);
	assign begin_save = save_req & ~save_q & ~begin_load;
	assign xfer_start = (state == BK_IDLE) & (begin_load | begin_save);

	assign block_done = (state == BK_XFER) & ack_q & ~sd_ack;
	assign last_block = (sd_lba >= lba_t'(ram_mask >> BLOCK_SHIFT));

	assign bk_busy = (state == BK_XFER);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			load_q <= 1'b0;
			save_q <= 1'b0;
			ack_q  <= 1'b0;
			bk_ena <= 1'b0;
		end else begin
			load_q <= load_req;
			save_q <= save_req;
			ack_q  <= sd_ack;
			if (stream.load_start) begin
				bk_ena <= 1'b0;
			end
			// Save file is mounted by the time the download runs
			if (stream.cart_active && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end
		end
	end

	// ====================
	// Block FSM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= BK_IDLE;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (xfer_start) begin
				state      <= BK_XFER;
				bk_loading <= begin_load;
				sd_rd      <= begin_load;
				sd_wr      <= ~begin_load;
			end else if (block_done && last_block) begin
				state      <= BK_IDLE;
				bk_loading <= 1'b0;
			end else if (block_done) begin
				sd_rd <= bk_loading;
				sd_wr <= ~bk_loading;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (xfer_start) begin
			sd_lba <= '0;
		end else if (block_done && !last_block) begin
			sd_lba <= sd_lba + 1'b1;
		end
	end

	// Writes made while the menu is open are not the game's own
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_open && bsram_write) begin
			bk_pending <= 1'b1;
		end else if (bk_busy) begin
			bk_pending <= 1'b0;
		end
	end

endmodule

//--- src/cart_loader_top.sv
// Work RAM, backup RAM and the SD buffer live outside; only fill and handshake signals leave here
`timescale 1ns/10ps

module cart_loader_top (
	input  logic                    clk_sys,
	input  logic                    RESET,

	// Host download
	input  logic                    ioctl_download,
	input  logic [7:0]              ioctl_index,
	input  logic                    ioctl_wr,
	input  cart_pkg::ioctl_addr_t   ioctl_addr,
	input  cart_pkg::word_t         ioctl_dout,

	// Menu options
	input  cart_pkg::header_mode_e  rom_header_mode,
	input  cart_pkg::region_sel_e   video_region,
	input  cart_pkg::fill_pattern_e wram_pattern,

	// Cartridge configuration
	output cart_pkg::rom_type_t     rom_type,
	output cart_pkg::mask_t         rom_mask,
	output cart_pkg::mask_t         ram_mask,
	output logic                    pal,
	output cart_pkg::cheat_code_t   gg_code,
	output logic                    gg_reset,

	// Work RAM clear
	output cart_pkg::fill_addr_t    fill_addr,
	output logic [7:0]              fill_data,
	output logic                    fill_we,

	// Backup RAM and SD card
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic [63:0]             img_size,
	input  logic                    bk_load,
	input  logic                    bk_save,
	input  logic                    autosave,
	input  logic                    osd_open,
	input  logic                    bsram_write,
	output cart_pkg::lba_t          sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	input  logic                    sd_ack,
	output logic                    bk_busy,
	output logic                    bk_loading,
	output logic                    bk_pending
);
	cart_stream_if stream ();

	load_stream_decode u_decode (
		.clk_sys, .RESET, .ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.stream (stream.source)
	);

	header_parser u_header (
		.clk_sys, .RESET, .stream (stream.sink), .rom_header_mode, .video_region,
		.rom_type, .rom_mask, .ram_mask, .pal
	);

	cheat_assembler u_cheat (
		.clk_sys, .RESET, .stream (stream.sink), .gg_code, .gg_reset
	);

	ram_clear u_clear (
		.clk_sys, .RESET, .stream (stream.sink), .wram_pattern, .fill_addr, .fill_data, .fill_we
	);

	backup_sequencer u_backup (
		.clk_sys, .RESET, .stream (stream.sink), .ram_mask, .img_mounted, .img_readonly,
		.img_size, .bk_load, .bk_save, .autosave, .osd_open, .bsram_write,
		.sd_lba, .sd_rd, .sd_wr, .sd_ack, .bk_busy, .bk_loading, .bk_pending
	);

endmodule

//--- src/cart_pkg.sv
// Shared widths and encodings; header offsets assume a 512-byte copier header in front of the ROM
package cart_pkg;

	// ====================
	// Widths
	// ====================
	typedef logic [15:0]  word_t;
	typedef logic [24:0]  ioctl_addr_t;
	typedef logic [23:0]  mask_t;
	typedef logic [3:0]   size_code_t;
	typedef logic [7:0]   rom_type_t;
	typedef logic [16:0]  fill_addr_t;
	typedef logic [31:0]  lba_t;
	// Clock bit, flags, address, compare, replace
	typedef logic [128:0] cheat_code_t;

	// ====================
	// Menu selections and FSM
	// ====================
	typedef enum logic [2:0] {HDR_AUTO, HDR_NONE, HDR_LOROM, HDR_HIROM, HDR_EXHIROM} header_mode_e;
	typedef enum logic [1:0] {REG_AUTO, REG_NTSC, REG_PAL} region_sel_e;
	typedef enum logic [1:0] {FILL_9966, FILL_00FF, FILL_55, FILL_FF} fill_pattern_e;
	typedef enum logic {BK_IDLE, BK_XFER} bk_state_e;

	// ====================
	// Constants
	// ====================
	localparam logic [7:0] CODE_INDEX       = 8'hFF;
	localparam ioctl_addr_t COPIER_HDR      = 25'h200;
	localparam ioctl_addr_t LOROM_HDR       = 25'h7FD6;
	localparam ioctl_addr_t HIROM_HDR       = 25'hFFD6;
	localparam ioctl_addr_t EXHIROM_HDR     = 25'h40FFD6;
	localparam ioctl_addr_t RAMSIZE_OFS     = 25'd2;
	localparam size_code_t DEFAULT_ROM_SIZE = 4'hC;
	localparam mask_t MASK_UNIT             = 24'd1024;
	localparam logic [7:0] FILL_BYTE_66     = 8'h66;
	localparam logic [7:0] FILL_BYTE_99     = 8'h99;
	localparam logic [7:0] FILL_BYTE_FF     = 8'hFF;
	localparam logic [7:0] FILL_BYTE_00     = 8'h00;
	localparam logic [7:0] FILL_BYTE_55     = 8'h55;
	localparam int BLOCK_SHIFT              = 9;

endpackage

//--- src/cart_stream_if.sv
// Classified download stream; all signals are in the clk_sys domain and strobes last one cycle
`timescale 1ns/10ps

interface cart_stream_if;

	// Stream class, levels
	logic                 cart_active;
	logic                 code_active;

	// One strobe per word
	logic                 wr;
	cart_pkg::ioctl_addr_t addr;
	cart_pkg::word_t       data;

	// Edges of the cartridge download
	logic                 load_start;
	logic                 load_end;

	modport source (output cart_active, code_active, wr, addr, data, load_start, load_end);
	modport sink (input cart_active, code_active, wr, addr, data, load_start, load_end);

endinterface

//--- src/cheat_assembler.sv
// Fields arrive as big-endian words in the order the loader sends them; only the word at 14 fires
`timescale 1ns/10ps

module cheat_assembler (
	input  logic                  clk_sys,
	input  logic                  RESET,
	cart_stream_if.sink           stream,
	output cart_pkg::cheat_code_t gg_code,
	output logic                  gg_reset
);
	logic         code_wr;
	logic         gg_clk;
	logic [127:0] gg_fields;

	assign code_wr = stream.code_active & stream.wr;

	// Field placement by byte offset within an 8-word record
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (stream.addr[3:0])
				4'd0:  gg_fields[111:96]  <= stream.data;
				4'd2:  gg_fields[127:112] <= stream.data;
				4'd4:  gg_fields[79:64]   <= stream.data;
				4'd6:  gg_fields[95:80]   <= stream.data;
				4'd8:  gg_fields[47:32]   <= stream.data;
				4'd10: gg_fields[63:48]   <= stream.data;
				4'd12: gg_fields[15:0]    <= stream.data;
				4'd14: gg_fields[31:16]   <= stream.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg_clk   <= 1'b0;
			gg_reset <= 1'b0;
		end else begin
			gg_clk   <= code_wr & (stream.addr[3:0] == 4'd14);
			// Drop the code list on a new cartridge or a new code file
			gg_reset <= stream.cart_active | (code_wr & (stream.addr == '0));
		end
	end

	assign gg_code = {gg_clk, gg_fields};

endmodule

//--- src/header_parser.sv
// Fixed modes trust the header at its standard offset; auto mode needs the size byte at address 0
`timescale 1ns/10ps

module header_parser (
	input  logic                   clk_sys,
	input  logic                   RESET,
	cart_stream_if.sink            stream,
	input  cart_pkg::header_mode_e rom_header_mode,
	input  cart_pkg::region_sel_e  video_region,
	output cart_pkg::rom_type_t    rom_type,
	output cart_pkg::mask_t        rom_mask,
	output cart_pkg::mask_t        ram_mask,
	output logic                   pal
);
	import cart_pkg::*;

	size_code_t  rom_size;
	size_code_t  ram_size;
	logic        region;
	logic        cart_wr;
	logic        fixed_mode;
	ioctl_addr_t hdr_base;
	ioctl_addr_t rom_size_addr;
	ioctl_addr_t ram_size_addr;

	assign cart_wr = stream.cart_active & stream.wr;

	// Header location for the forced layouts
	always_comb begin
		fixed_mode = 1'b1;
		case (rom_header_mode)
			HDR_LOROM:   hdr_base = LOROM_HDR;
			HDR_HIROM:   hdr_base = HIROM_HDR;
			HDR_EXHIROM: hdr_base = EXHIROM_HDR;
			default: begin
				hdr_base   = '0;
				fixed_mode = 1'b0;
			end
		endcase
	end

	assign rom_size_addr = hdr_base + COPIER_HDR;
	assign ram_size_addr = rom_size_addr + RAMSIZE_OFS;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size <= DEFAULT_ROM_SIZE;
			ram_size <= '0;
			rom_type <= '0;
			region   <= 1'b0;
		end else if (cart_wr) begin
			if (stream.addr == '0) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= '0;
				// Packed size byte from the loader, RAM in the upper nibble
				if (rom_header_mode == HDR_AUTO && stream.data[7:0] != 8'h00) begin
					ram_size <= stream.data[7:4];
					rom_size <= stream.data[3:0];
				end
				case (rom_header_mode)
					HDR_NONE, HDR_LOROM: rom_type <= 8'd0;
					HDR_HIROM:           rom_type <= 8'd1;
					HDR_EXHIROM:         rom_type <= 8'd2;
					default:             rom_type <= stream.data[15:8];
				endcase
			end
			if (stream.addr == 25'd2) begin
				region <= stream.data[8];
			end
			if (fixed_mode && stream.addr == rom_size_addr) begin
				rom_size <= stream.data[11:8];
			end
			if (fixed_mode && stream.addr == ram_size_addr) begin
				ram_size <= stream.data[3:0];
			end
		end
	end

	assign rom_mask = (MASK_UNIT << rom_size) - mask_t'(1);
	assign ram_mask = (ram_size == '0) ? '0 : (MASK_UNIT << ram_size) - mask_t'(1);

	// Region only switches between downloads
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal <= 1'b0;
		end else if (!stream.cart_active) begin
			pal <= (video_region == REG_AUTO) ? region : (video_region == REG_PAL);
		end
	end

endmodule

//--- src/load_stream_decode.sv
// Any index other than all ones counts as a cartridge; writes pass through without any stall
`timescale 1ns/10ps

module load_stream_decode (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  ioctl_download,
	input  logic [7:0]            ioctl_index,
	input  logic                  ioctl_wr,
	input  cart_pkg::ioctl_addr_t ioctl_addr,
	input  cart_pkg::word_t       ioctl_dout,
	cart_stream_if.source         stream
);
	import cart_pkg::*;

	logic is_code;
	logic cart_q;

	assign is_code = (ioctl_index == CODE_INDEX);

	assign stream.cart_active = ioctl_download & ~is_code;
	assign stream.code_active = ioctl_download & is_code;

	// Previous cartridge level for the edges
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_q <= 1'b0;
		end else begin
			cart_q <= stream.cart_active;
		end
	end

	assign stream.load_start = stream.cart_active & ~cart_q;
	assign stream.load_end   = ~stream.cart_active & cart_q;

	assign stream.wr   = ioctl_wr;
	assign stream.addr = ioctl_addr;
	assign stream.data = ioctl_dout;

endmodule

//--- src/ram_clear.sv
// Sweep covers 128 KiB of work RAM; a load starting mid-sweep does not restart it
`timescale 1ns/10ps

module ram_clear (
	input  logic                    clk_sys,
	input  logic                    RESET,
	cart_stream_if.sink             stream,
	input  cart_pkg::fill_pattern_e wram_pattern,
	output cart_pkg::fill_addr_t    fill_addr,
	output logic [7:0]              fill_data,
	output logic                    fill_we
);
	import cart_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			fill_we   <= 1'b0;
			fill_addr <= '0;
		end else begin
			if (!fill_we && stream.load_start) begin
				fill_we <= 1'b1;
			end else if (fill_we && (&fill_addr)) begin
				fill_we <= 1'b0;
			end
			// Wraps back to zero with the last write
			fill_addr <= fill_we ? fill_addr + 1'b1 : '0;
		end
	end

	// Power-on patterns of the different console revisions
	always_comb begin
		case (wram_pattern)
			FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? FILL_BYTE_66 : FILL_BYTE_99;
			FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? FILL_BYTE_FF : FILL_BYTE_00;
			FILL_55:   fill_data = FILL_BYTE_55;
			default:   fill_data = FILL_BYTE_FF;
		endcase
	end

endmodule

//--- tb/tb_cart_loader.sv
// Runs six full 128K-cycle work RAM sweeps; the SD model answers every request with a random ack length
`timescale 1ns/10ps

module tb_cart_loader;
	import cart_pkg::*;

	localparam int NUM_ROWS        = 6;
	localparam int SWEEP_LEN       = 131072;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * (SWEEP_LEN + 2000) + 20000;

	logic          clk_sys;
	logic          RESET;
	logic          ioctl_download;
	logic [7:0]    ioctl_index;
	logic          ioctl_wr;
	ioctl_addr_t   ioctl_addr;
	word_t         ioctl_dout;
	header_mode_e  rom_header_mode;
	region_sel_e   video_region;
	fill_pattern_e wram_pattern;
	rom_type_t     rom_type;
	mask_t         rom_mask;
	mask_t         ram_mask;
	logic          pal;
	cheat_code_t   gg_code;
	logic          gg_reset;
	fill_addr_t    fill_addr;
	logic [7:0]    fill_data;
	logic          fill_we;
	logic          img_mounted;
	logic          img_readonly;
	logic [63:0]   img_size;
	logic          bk_load;
	logic          bk_save;
	logic          autosave;
	logic          osd_open;
	logic          bsram_write;
	lba_t          sd_lba;
	logic          sd_rd;
	logic          sd_wr;
	logic          sd_ack;
	logic          bk_busy;
	logic          bk_loading;
	logic          bk_pending;

	// Requests seen by the SD model
	lba_t req_lba [$];
	logic req_read [$];
	logic req_write [$];

	typedef struct packed {
		header_mode_e  mode;
		region_sel_e   region;
		fill_pattern_e pattern;
		word_t         w0;
		word_t         w2;
		ioctl_addr_t   hdr_addr;
		word_t         rom_word;
		word_t         ram_word;
		rom_type_t     exp_type;
		mask_t         exp_rom_mask;
		mask_t         exp_ram_mask;
		logic          exp_pal;
	} case_row_t;

	// ====================
	// Case table
	// ====================
	// Header address is the layout base plus the 0x200 copier header, 0 when unused
	case_row_t rows [NUM_ROWS] = '{
		'{HDR_NONE, REG_PAL, FILL_55, 16'h7755, 16'h0000, 25'h0, 16'h0000, 16'h0000,
			8'h00, 24'h3FFFFF, 24'h000000, 1'b1},
		'{HDR_AUTO, REG_NTSC, FILL_00FF, 16'h1200, 16'h0100, 25'h0, 16'h0000, 16'h0000,
			8'h12, 24'h3FFFFF, 24'h000000, 1'b0},
		'{HDR_EXHIROM, REG_NTSC, FILL_00FF, 16'h0000, 16'h0000, 25'h4101D6, 16'h0D00, 16'h0000,
			8'h02, 24'h7FFFFF, 24'h000000, 1'b0},
		'{HDR_LOROM, REG_AUTO, FILL_FF, 16'h0000, 16'h0000, 25'h0081D6, 16'h0A00, 16'h0001,
			8'h00, 24'h0FFFFF, 24'h0007FF, 1'b0},
		'{HDR_HIROM, REG_AUTO, FILL_9966, 16'h33C3, 16'h0100, 25'h0101D6, 16'h0B00, 16'h0005,
			8'h01, 24'h1FFFFF, 24'h007FFF, 1'b1},
		'{HDR_AUTO, REG_AUTO, FILL_9966, 16'h0531, 16'h0100, 25'h0, 16'h0000, 16'h0000,
			8'h05, 24'h0007FF, 24'h001FFF, 1'b1}
	};

	cart_loader_top u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ====================
	// Reporting
	// ====================
	task automatic check_equal(input string name, input logic [128:0] got,
			input logic [128:0] exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Run aborted");
	endtask

	// Power-on pattern per address
	function automatic logic [7:0] fill_byte(input fill_pattern_e p, input fill_addr_t a);
		case (p)
			FILL_9966: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			FILL_00FF: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			FILL_55:   return 8'h55;
			default:   return 8'hFF;
		endcase
	endfunction

	// ====================
	// Host and SD models
	// ====================
	task automatic put_word(input ioctl_addr_t a, input word_t d);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= a;
		ioctl_dout <= d;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	task automatic cart_download(input int r);
		ioctl_addr_t a;
		@(posedge clk_sys);
		ioctl_index    <= 8'h00;
		ioctl_download <= 1'b1;
		put_word(25'd0, rows[r].w0);
		put_word(25'd2, rows[r].w2);
		for (a = 25'd4; a < 25'd16; a = a + 25'd2) begin
			put_word(a, word_t'($urandom));
		end
		if (rows[r].hdr_addr != '0) begin
			put_word(rows[r].hdr_addr, rows[r].rom_word);
			put_word(rows[r].hdr_addr + 25'd2, rows[r].ram_word);
		end
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_equal("gg_reset", gg_reset, 1'b1);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	initial begin : sd_model
		int len;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				req_lba.push_back(sd_lba);
				req_read.push_back(sd_rd);
				req_write.push_back(sd_wr);
				len = 1 + ($urandom % 6);
				@(posedge clk_sys);
				sd_ack <= 1'b1;
				repeat (len) @(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	// ====================
	// Monitors
	// ====================
	task automatic check_sweep(input fill_pattern_e p);
		int n;
		int count;
		n = 0;
		while (!fill_we) begin
			@(negedge clk_sys);
			n++;
			if (n > 100) abort_run("fill_we did not rise after the cartridge load started");
		end
		count = 0;
		while (fill_we) begin
			check_equal("fill_addr", fill_addr, count);
			check_equal("fill_data", fill_data, fill_byte(p, fill_addr_t'(count)));
			count++;
			@(negedge clk_sys);
		end
		check_equal("fill_we cycles", count, SWEEP_LEN);
	endtask

	task automatic check_transfer(input mask_t mask, input logic is_save);
		int n;
		int i;
		int blocks;
		blocks = int'(mask >> 9) + 1;
		n = 0;
		while (!bk_busy) begin
			@(negedge clk_sys);
			n++;
			if (n > 1000) abort_run("Backup transfer did not start");
		end
		n = 0;
		while (bk_busy) begin
			check_equal("bk_loading", bk_loading, !is_save);
			@(negedge clk_sys);
			n++;
			if (n > blocks * 40) abort_run("Backup transfer did not finish");
		end
		check_equal("block count", req_lba.size(), blocks);
		for (i = 0; i < blocks; i++) begin
			check_equal("sd_lba", req_lba[i], i);
			check_equal("sd_rd", req_read[i], !is_save);
			check_equal("sd_wr", req_write[i], is_save);
		end
	endtask

	// ====================
	// Test steps
	// ====================
	task automatic run_cheat_test();
		word_t        w [8];
		logic [127:0] expected;
		logic [127:0] captured;
		int           pulses;
		int           i;
		logic         reset_seen;
		logic         done;
		for (i = 0; i < 8; i++) begin
			w[i] = word_t'($urandom);
		end
		// Flags, address, compare, replace; high word above low word
		expected = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		pulses = 0;
		captured = '0;
		reset_seen = 1'b0;
		done = 1'b0;
		@(posedge clk_sys);
		ioctl_index    <= 8'hFF;
		ioctl_download <= 1'b1;
		fork
			begin
				for (int k = 0; k < 8; k++) begin
					put_word(ioctl_addr_t'(2 * k), w[k]);
				end
				repeat (3) @(posedge clk_sys);
				ioctl_download <= 1'b0;
				repeat (2) @(posedge clk_sys);
				done = 1'b1;
			end
			begin
				while (!done) begin
					@(negedge clk_sys);
					if (gg_code[128]) begin
						pulses++;
						captured = gg_code[127:0];
					end
					if (gg_reset) reset_seen = 1'b1;
				end
			end
		join
		check_equal("gg_code clock pulses", pulses, 1);
		check_equal("gg_code", captured, expected);
		check_equal("gg_reset on code start", reset_seen, 1'b1);
	endtask

	task automatic run_row(input int r);
		@(posedge clk_sys);
		rom_header_mode <= rows[r].mode;
		video_region    <= rows[r].region;
		wram_pattern    <= rows[r].pattern;
		req_lba.delete();
		req_read.delete();
		req_write.delete();
		fork
			cart_download(r);
			check_sweep(rows[r].pattern);
			if (rows[r].exp_ram_mask != '0) check_transfer(rows[r].exp_ram_mask, 1'b0);
		join
		check_equal("rom_type", rom_type, rows[r].exp_type);
		check_equal("rom_mask", rom_mask, rows[r].exp_rom_mask);
		check_equal("ram_mask", ram_mask, rows[r].exp_ram_mask);
		check_equal("pal", pal, rows[r].exp_pal);
	endtask

	// Last row leaves the backup RAM enabled
	task automatic run_autosave_test();
		@(posedge clk_sys);
		req_lba.delete();
		req_read.delete();
		req_write.delete();
		bsram_write <= 1'b1;
		@(posedge clk_sys);
		bsram_write <= 1'b0;
		@(negedge clk_sys);
		check_equal("bk_pending", bk_pending, 1'b1);
		@(posedge clk_sys);
		autosave <= 1'b1;
		osd_open <= 1'b1;
		check_transfer(rows[NUM_ROWS-1].exp_ram_mask, 1'b1);
		check_equal("bk_pending", bk_pending, 1'b0);
		@(posedge clk_sys);
		osd_open <= 1'b0;
		autosave <= 1'b0;
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		abort_run("Timeout: the tests did not finish in the expected number of cycles");
	end

	initial begin : main_seq
		void'($urandom(87));
		RESET           = 1'b1;
		ioctl_download  = 1'b0;
		ioctl_index     = 8'h00;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_dout      = '0;
		rom_header_mode = HDR_AUTO;
		video_region    = REG_AUTO;
		wram_pattern    = FILL_9966;
		img_mounted     = 1'b1;
		img_readonly    = 1'b0;
		img_size        = 64'h2000;
		bk_load         = 1'b0;
		bk_save         = 1'b0;
		autosave        = 1'b0;
		osd_open        = 1'b0;
		bsram_write     = 1'b0;
		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;

		run_cheat_test();
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		run_autosave_test();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
